//--- dv/imgproc_tb.sv
`timescale 1ns/10ps
`include "imgproc_params.svh"

module imgproc_tb;

	localparam int TIMEOUT    = 4000;          // Cycles allowed for any single wait
	localparam int FRAME_PIX  = `IMAGE_W * 4;  // Short frames of four lines
	localparam int NUM_FRAMES = 13;

	logic                clk;
	logic                reset_n;
	logic [23:0]         sink_data;
	logic                sink_valid;
	logic                sink_ready;
	logic                sink_sop;
	logic                sink_eop;
	logic [23:0]         source_data;
	logic                source_valid;
	logic                source_ready = 1'b0;
	logic                source_sop;
	logic                source_eop;
	logic                mode;
	logic                s_chipselect;
	logic                s_read;
	logic                s_write;
	host_pkg::reg_addr_t s_address;
	logic [31:0]         s_readdata;
	logic [31:0]         s_writedata;

	video_pkg::video_beat_t exp_q[$];   // Expected source beats in order
	host_pkg::msg_word_t    msg_q[$];   // Expected queue contents
	string                  test_name;
	int                     bp_pct;     // Percent of cycles with source_ready low
	logic                   mode_sel;
	video_pkg::pixel_t      col_sel;
	logic [7:0]             status_sel;

	// Reference model state
	logic                   m_video;
	logic                   m_hit;
	video_pkg::coord_t      m_x;
	video_pkg::coord_t      m_y;
	video_pkg::coord_t      m_left;
	video_pkg::coord_t      m_right;
	video_pkg::coord_t      m_top;
	video_pkg::coord_t      m_bottom;
	video_pkg::box_t        m_box;
	int                     m_frame_cnt;

	// Window that holds the bright pixels of the current packet
	int                     win_x0;
	int                     win_w;
	int                     win_y0;
	int                     win_y1;

	eee_imgproc eee_imgproc_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.mode         (mode),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_readdata   (s_readdata),
		.s_writedata  (s_writedata)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_beat(video_pkg::video_beat_t exp, video_pkg::video_beat_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERROR %s: expected %h, actual %h", test_name, exp, act));
		end
	endtask

	task automatic check_msg(host_pkg::msg_word_t exp, host_pkg::msg_word_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERROR %s: expected %h, actual %h", test_name, exp, act));
		end
	endtask

	task automatic check_reg(logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			abort_run($sformatf("ERROR %s: expected %h, actual %h", test_name, exp, act));
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic is_bright(video_pkg::pixel_t p);
		return p.red[7] & p.green[7] & p.blue[7];
	endfunction

	// Beat as it should leave the overlay for the model state before it
	function automatic video_pkg::video_beat_t expect_beat(video_pkg::video_beat_t b);
		video_pkg::video_beat_t e;
		logic                   edge_hit;
		int                     grey_sum;
		e = b;
		if (mode_sel && m_video && !b.sop) begin
			edge_hit = m_box.found && (m_x == m_box.left || m_x == m_box.right ||
				m_y == m_box.top || m_y == m_box.bottom);
			grey_sum = b.pixel.green / 2 + b.pixel.red / 4 + b.pixel.blue / 4;
			if (edge_hit) begin
				e.pixel = col_sel;
			end else if (is_bright(b.pixel)) begin
				e.pixel = 24'hffffff;
			end else begin
				e.pixel = {3{grey_sum[7:0]}};
			end
		end
		return e;
	endfunction

	function automatic void schedule_report();
		if (m_frame_cnt == 0 && msg_q.size() <= `MSG_FIFO_DEPTH - 3) begin
			msg_q.push_back(`MSG_TAG);
			msg_q.push_back({16'(m_box.left), 16'(m_box.top)});
			msg_q.push_back({16'(m_box.right), 16'(m_box.bottom)});
			m_frame_cnt = `MSG_INTERVAL - 1;
		end else if (m_frame_cnt != 0) begin
			m_frame_cnt = m_frame_cnt - 1;
		end
	endfunction

	function automatic void step_model(video_pkg::video_beat_t b);
		if (b.sop) begin
			m_video  = (b.pixel.blue[3:0] == 4'h0);  // Descriptor marks the packet type
			m_x      = '0;
			m_y      = '0;
			m_hit    = 1'b0;
			m_left   = '1;
			m_top    = '1;
			m_right  = '0;
			m_bottom = '0;
		end else begin
			if (m_video && is_bright(b.pixel)) begin
				m_hit = 1'b1;
				if (m_x < m_left) begin
					m_left = m_x;
				end
				if (m_x > m_right) begin
					m_right = m_x;
				end
				if (m_y < m_top) begin
					m_top = m_y;
				end
				if (m_y > m_bottom) begin
					m_bottom = m_y;
				end
			end
			if (b.eop && m_video) begin
				m_box = '{found: m_hit, left: m_left, right: m_right,
					top: m_top, bottom: m_bottom};
				schedule_report();
			end
			if (m_x == `IMAGE_W - 1) begin
				m_x = '0;
				m_y = m_y + 1'b1;
			end else begin
				m_x = m_x + 1'b1;
			end
		end
	endfunction

	function automatic logic [31:0] status_word();
		return {16'h0000, 8'(msg_q.size()), status_sel};
	endfunction

	//////////////////////////////////////////////////////////////
	// Stream driver and monitor

	function automatic video_pkg::pixel_t random_pixel(int idx);
		video_pkg::pixel_t p;
		int                col;
		int                row;
		logic              in_win;
		p      = 24'($urandom);
		col    = idx % `IMAGE_W;
		row    = idx / `IMAGE_W;
		in_win = (col >= win_x0 && col < win_x0 + win_w && row >= win_y0 && row <= win_y1);
		if (in_win && $urandom_range(7) == 0) begin
			p.red[7]   = 1'b1;
			p.green[7] = 1'b1;
			p.blue[7]  = 1'b1;
		end else begin
			case ($urandom_range(2))  // Clear one channel MSB so it stays dark
				0:       p.red[7] = 1'b0;
				1:       p.green[7] = 1'b0;
				default: p.blue[7] = 1'b0;
			endcase
		end
		return p;
	endfunction

	task automatic push_beat(video_pkg::video_beat_t b);
		int waited;
		exp_q.push_back(expect_beat(b));
		step_model(b);
		@(posedge clk);
		sink_valid <= 1'b1;
		sink_data  <= b.pixel;
		sink_sop   <= b.sop;
		sink_eop   <= b.eop;
		waited = 0;
		@(negedge clk);
		while (!sink_ready) begin
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("Timeout: sink_ready stayed low and the input stream is stuck");
			end
			@(negedge clk);
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		sink_valid <= 1'b0;
	endtask

	task automatic send_packet(logic is_video, int npix, int gap_pct);
		video_pkg::video_beat_t b;
		win_w  = 32 + $urandom_range(200);
		win_x0 = $urandom_range(`IMAGE_W - win_w);
		win_y0 = $urandom_range(3);
		win_y1 = win_y0 + $urandom_range(3 - win_y0);
		b.pixel = 24'($urandom);
		b.pixel.blue[3:0] = is_video ? 4'h0 : 4'(1 + $urandom_range(14));
		b.sop = 1'b1;
		b.eop = 1'b0;
		push_beat(b);
		for (int i = 0; i < npix; i++) begin
			if (int'($urandom_range(99)) < gap_pct) begin
				idle_cycle();
			end
			b.pixel = random_pixel(i);
			b.sop   = 1'b0;
			b.eop   = (i == npix - 1);
			push_beat(b);
		end
		idle_cycle();
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				abort_run($sformatf("Timeout: output stream stalled with %0d beats missing",
					exp_q.size()));
			end
		end
		repeat (4) @(posedge clk);  // Report words land three cycles after the eop
	endtask

	always @(posedge clk) begin
		source_ready <= (int'($urandom_range(99)) >= bp_pct);
	end

	always @(negedge clk) begin : monitor
		video_pkg::video_beat_t act;
		video_pkg::video_beat_t exp;
		if (reset_n && source_valid && source_ready) begin
			act = {source_data, source_sop, source_eop};
			if (exp_q.size() == 0) begin
				abort_run("Source port delivered a beat that was never sent");
			end else begin
				exp = exp_q.pop_front();
				check_beat(exp, act);
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Register port

	task automatic reg_write(host_pkg::reg_addr_t addr, logic [31:0] data);
		@(posedge clk);
		s_chipselect <= 1'b1;
		s_write      <= 1'b1;
		s_address    <= addr;
		s_writedata  <= data;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write      <= 1'b0;
	endtask

	task automatic reg_read(host_pkg::reg_addr_t addr, output logic [31:0] data);
		@(posedge clk);
		s_chipselect <= 1'b1;
		s_read       <= 1'b1;
		s_address    <= addr;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read       <= 1'b0;
		@(negedge clk);
		data = s_readdata;  // Registered one cycle after the strobe
	endtask

	task automatic expect_reg(host_pkg::reg_addr_t addr, logic [31:0] exp);
		logic [31:0] data;
		reg_read(addr, data);
		check_reg(exp, data);
	endtask

	// Read out every queued word while the fill count falls
	task automatic drain_messages();
		logic [31:0]         data;
		host_pkg::msg_word_t exp;
		while (msg_q.size() != 0) begin
			test_name = "status_fill";
			expect_reg(`REG_STATUS, status_word());
			test_name = "msg_word";
			reg_read(`REG_MSG, data);
			exp = msg_q.pop_front();
			check_msg(exp, data);
		end
		test_name = "status_empty";
		expect_reg(`REG_STATUS, status_word());
	endtask

	//////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] wdata;
		void'($urandom(32'hf6f1));
		reset_n      = 1'b0;
		sink_data    = '0;
		sink_valid   = 1'b0;
		sink_sop     = 1'b0;
		sink_eop     = 1'b0;
		mode         = 1'b0;
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		s_write      = 1'b0;
		s_address    = '0;
		s_writedata  = '0;
		bp_pct       = 0;
		mode_sel     = 1'b0;
		col_sel      = `BB_COL_DEFAULT;
		status_sel   = 8'h00;
		m_video      = 1'b0;
		m_x          = '0;
		m_y          = '0;
		m_box        = '0;
		m_frame_cnt  = 0;
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;

		@(negedge clk);
		test_name = "reset_readdata";
		if (source_valid !== 1'b0 || sink_ready !== 1'b1) begin
			abort_run("Stream handshake is wrong right after reset");
		end
		check_reg(32'h0, s_readdata);
		test_name = "id_word";
		expect_reg(`REG_ID, `ID_WORD);
		test_name = "bbcol_default";
		expect_reg(`REG_BBCOL, {8'h00, `BB_COL_DEFAULT});
		test_name = "status_reset";
		expect_reg(`REG_STATUS, status_word());

		for (int f = 0; f < NUM_FRAMES; f++) begin
			mode_sel = (f < 3) ? 1'b1 : f[0];  // Overlay on three frames and alternating after
			bp_pct   = (f == 0) ? 0 : 10 * (f % 5);
			if (f == 2) begin
				col_sel = 24'($urandom);
				reg_write(`REG_BBCOL, {8'ha5, col_sel});
				test_name = "bbcol_write";
				expect_reg(`REG_BBCOL, {8'h00, col_sel});
			end
			@(posedge clk);
			mode <= mode_sel;
			test_name = $sformatf("frame%0d_beat", f);
			send_packet(1'b1, FRAME_PIX, (f % 3) * 10);
			wait_drain();
			if (f < 2 && !m_box.found) begin
				abort_run("A frame before the colour write held no bright pixel so box edges go untested");
			end
			if (f % 4 == 2) begin
				test_name = $sformatf("nonvideo%0d_beat", f);
				send_packet(1'b0, 20 + $urandom_range(60), 10);
				wait_drain();
			end
			if (f < NUM_FRAMES - 1) begin
				drain_messages();
			end
		end

		// Last report is left in the queue and flushed
		test_name = "flush";
		if (msg_q.size() == 0) begin
			abort_run("No report was queued before the flush");
		end
		wdata = $urandom | 32'h10;
		reg_write(`REG_STATUS, wdata);
		msg_q.delete();
		status_sel = wdata[7:0] & 8'hef;
		expect_reg(`REG_STATUS, status_word());

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module imgproc_tb -f sim.f -o imgproc_sim
./obj_dir/imgproc_sim

//--- sim.f
+incdir+src
src/video_pkg.sv
src/host_pkg.sv
src/stream_stage.sv
src/frame_tracker.sv
src/pixel_overlay.sv
src/msg_queue.sv
src/host_regs.sv
src/eee_imgproc.sv
dv/imgproc_tb.sv

//--- src/eee_imgproc.sv
`timescale 1ns/10ps

module eee_imgproc (
	input  logic                clk,
	input  logic                reset_n,

	// Video in
	input  logic [23:0]         sink_data,
	input  logic                sink_valid,
	output logic                sink_ready,
	input  logic                sink_sop,
	input  logic                sink_eop,

	// Video out
	output logic [23:0]         source_data,
	output logic                source_valid,
	input  logic                source_ready,
	output logic                source_sop,
	output logic                source_eop,

	input  logic                mode,             // High enables the overlay

	// Register port
	input  logic                s_chipselect,
	input  logic                s_read,
	input  logic                s_write,
	input  host_pkg::reg_addr_t s_address,
	output logic [31:0]         s_readdata,
	input  logic [31:0]         s_writedata
);

	video_pkg::video_beat_t sink_beat;
	video_pkg::video_beat_t held_beat;
	video_pkg::video_beat_t ovl_beat;
	video_pkg::video_beat_t source_beat;
	logic                   held_valid;
	logic                   held_ready;
	logic                   advance;
	logic                   frame_done;
	logic                   video;
	video_pkg::coord_t      x;
	video_pkg::coord_t      y;
	video_pkg::box_t        box;
	video_pkg::pixel_t      bb_col;
	logic                   flush;
	logic                   pop;
	host_pkg::msg_word_t    head;
	host_pkg::fill_t        fill;

	assign sink_beat = {sink_data, sink_sop, sink_eop};
	assign {source_data, source_sop, source_eop} = source_beat;
	assign advance = held_valid & held_ready;  // Held beat moves into out_stage

	//////////////////////////////////////////////////////////////
	// Stream path

	stream_stage #(.payload_t(video_pkg::video_beat_t)) in_stage (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (sink_valid),
		.in_ready  (sink_ready),
		.in_data   (sink_beat),
		.out_valid (held_valid),
		.out_ready (held_ready),
		.out_data  (held_beat)
	);

	frame_tracker frame_tracker_inst (
		.clk        (clk),
		.reset_n    (reset_n),
		.beat       (held_beat),
		.advance    (advance),
		.frame_done (frame_done),
		.video      (video),
		.x          (x),
		.y          (y),
		.box        (box)
	);

	pixel_overlay pixel_overlay_inst (
		.beat     (held_beat),
		.mode     (mode),
		.video    (video),
		.x        (x),
		.y        (y),
		.box      (box),
		.bb_col   (bb_col),
		.out_beat (ovl_beat)
	);

	stream_stage #(.payload_t(video_pkg::video_beat_t)) out_stage (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (held_valid),
		.in_ready  (held_ready),
		.in_data   (ovl_beat),
		.out_valid (source_valid),
		.out_ready (source_ready),
		.out_data  (source_beat)
	);

	//////////////////////////////////////////////////////////////
	// Messages and registers

	msg_queue msg_queue_inst (
		.clk        (clk),
		.reset_n    (reset_n),
		.frame_done (frame_done),
		.box        (box),
		.flush      (flush),
		.pop        (pop),
		.head       (head),
		.fill       (fill)
	);

	host_regs host_regs_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata),
		.head         (head),
		.fill         (fill),
		.bb_col       (bb_col),
		.flush        (flush),
		.pop          (pop)
	);

endmodule

//--- src/frame_tracker.sv
`timescale 1ns/10ps
`include "imgproc_params.svh"

module frame_tracker (
	input  logic                   clk,
	input  logic                   reset_n,
	input  video_pkg::video_beat_t beat,
	input  logic                   advance,     // Held beat moves on this cycle
	output logic                   frame_done,
	output logic                   video,
	output video_pkg::coord_t      x,
	output video_pkg::coord_t      y,
	output video_pkg::box_t        box
);

	video_pkg::coord_t x_min;
	video_pkg::coord_t x_max;
	video_pkg::coord_t y_min;
	video_pkg::coord_t y_max;
	video_pkg::coord_t nxt_x_min;
	video_pkg::coord_t nxt_x_max;
	video_pkg::coord_t nxt_y_min;
	video_pkg::coord_t nxt_y_max;
	logic              hit;
	logic              nxt_hit;
	logic              bright;
	logic              pixel_hit;
	logic              last_x;
	logic              last_y;

	assign bright    = beat.pixel.red[7] & beat.pixel.green[7] & beat.pixel.blue[7];
	assign pixel_hit = advance & ~beat.sop & video & bright;
	assign last_x    = (x == video_pkg::coord_t'(`IMAGE_W - 1));
	assign last_y    = (y == video_pkg::coord_t'(`IMAGE_H - 1));

	// Eop of a video packet closes the frame
	assign frame_done = advance & ~beat.sop & beat.eop & video;

	// Running bounds with the current beat folded in
	assign nxt_x_min = (pixel_hit && x < x_min) ? x : x_min;
	assign nxt_x_max = (pixel_hit && x > x_max) ? x : x_max;
	assign nxt_y_min = (pixel_hit && y < y_min) ? y : y_min;
	assign nxt_y_max = (pixel_hit && y > y_max) ? y : y_max;
	assign nxt_hit   = hit | pixel_hit;

	//////////////////////////////////////////////////////////////
	// Coordinates, packet type and box latch

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x     <= '0;
			y     <= '0;
			video <= 1'b0;
			hit   <= 1'b0;
			box   <= '0;
		end else if (advance) begin
			if (beat.sop) begin
				video <= (beat.pixel.blue[3:0] == 4'h0);  // Descriptor says video
				x     <= '0;
				y     <= '0;
				hit   <= 1'b0;
			end else begin
				hit <= nxt_hit;
				if (last_x) begin
					x <= '0;
					if (!last_y) begin
						y <= y + 1'b1;  // Oversized packets stay on the last line
					end
				end else begin
					x <= x + 1'b1;
				end
				if (beat.eop && video) begin
					box <= '{found: nxt_hit, left: nxt_x_min, right: nxt_x_max,
						top: nxt_y_min, bottom: nxt_y_max};
				end
			end
		end
	end

	// Bounds restart empty on every descriptor
	always_ff @(posedge clk) begin
		if (advance) begin
			if (beat.sop) begin
				x_min <= '1;
				y_min <= '1;
				x_max <= '0;
				y_max <= '0;
			end else begin
				x_min <= nxt_x_min;
				x_max <= nxt_x_max;
				y_min <= nxt_y_min;
				y_max <= nxt_y_max;
			end
		end
	end

endmodule

//--- src/host_pkg.sv
package host_pkg;

	// Word address on the register port
	typedef logic [2:0] reg_addr_t;

	// One entry of the message queue
	typedef logic [31:0] msg_word_t;

	// Queue fill count, 0 to 16
	typedef logic [4:0] fill_t;

endpackage

//--- src/host_regs.sv
`timescale 1ns/10ps
`include "imgproc_params.svh"

module host_regs (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                s_chipselect,
	input  logic                s_read,
	input  logic                s_write,
	input  host_pkg::reg_addr_t s_address,
	input  logic [31:0]         s_writedata,
	output logic [31:0]         s_readdata,
	input  host_pkg::msg_word_t head,
	input  host_pkg::fill_t     fill,
	output video_pkg::pixel_t   bb_col,
	output logic                flush,
	output logic                pop
);

	logic [7:0] status_byte;
	logic       read_d;      // Read strobe of the previous cycle
	logic       wr_sel;
	logic       rd_sel;

	assign wr_sel = s_chipselect & s_write;
	assign rd_sel = s_chipselect & s_read;

	// Status bit 4 is a flush command
	assign flush = wr_sel & (s_address == `REG_STATUS) & s_writedata[4];

	// Advance the queue once per read, even if the strobe is held
	assign pop = rd_sel & ~read_d & (s_address == `REG_MSG);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status_byte <= 8'h00;
			bb_col      <= `BB_COL_DEFAULT;
		end else if (wr_sel) begin
			if (s_address == `REG_STATUS) begin
				status_byte <= {s_writedata[7:5], 1'b0, s_writedata[3:0]};
			end
			if (s_address == `REG_BBCOL) begin
				bb_col <= s_writedata[23:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d     <= 1'b0;
		end else begin
			read_d <= rd_sel;
			if (rd_sel) begin
				case (s_address)
					`REG_STATUS: s_readdata <= {16'h0000, 3'b000, fill, status_byte};
					`REG_MSG:    s_readdata <= head;
					`REG_ID:     s_readdata <= `ID_WORD;
					`REG_BBCOL:  s_readdata <= {8'h00, bb_col};
					default:     s_readdata <= '0;
				endcase
			end
		end
	end

endmodule

//--- src/imgproc_params.svh
`ifndef IMGPROC_PARAMS_SVH
`define IMGPROC_PARAMS_SVH

// Frame geometry in pixels
`define IMAGE_W 640
`define IMAGE_H 480

// Message queue
`define MSG_FIFO_DEPTH 16
`define MSG_INTERVAL   6              // Frames between two box reports
`define MSG_TAG        32'h00004242   // First word of every report

// Register port
`define BB_COL_DEFAULT 24'h00ff00     // Green
`define ID_WORD        32'h1234EEE2

`define REG_STATUS 3'd0
`define REG_MSG    3'd1
`define REG_ID     3'd2
`define REG_BBCOL  3'd3

`endif

//--- src/msg_queue.sv
`timescale 1ns/10ps
`include "imgproc_params.svh"

module msg_queue (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                frame_done,
	input  video_pkg::box_t     box,
	input  logic                flush,
	input  logic                pop,
	output host_pkg::msg_word_t head,
	output host_pkg::fill_t     fill
);

	localparam int PTR_W = $clog2(`MSG_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`MSG_INTERVAL);

	host_pkg::msg_word_t mem [`MSG_FIFO_DEPTH];
	host_pkg::msg_word_t wr_word;
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    frame_cnt;
	logic [1:0]          wr_step;    // 0 idle, 1 tag, 2 left/top, 3 right/bottom
	logic                start;
	logic                wr_en;
	logic                rd_en;

	//////////////////////////////////////////////////////////////
	// Report scheduler

	assign start = frame_done & ~flush & (frame_cnt == '0) & (wr_step == 2'd0) &
		(fill <= host_pkg::fill_t'(`MSG_FIFO_DEPTH - 3));

	always_comb begin
		case (wr_step)
			2'd1:    wr_word = `MSG_TAG;
			2'd2:    wr_word = {5'd0, box.left, 5'd0, box.top};
			default: wr_word = {5'd0, box.right, 5'd0, box.bottom};
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			wr_step   <= 2'd0;
		end else begin
			if (flush) begin
				wr_step <= 2'd0;  // Drop a report still in progress
			end else if (start) begin
				wr_step <= 2'd1;
			end else if (wr_step != 2'd0) begin
				wr_step <= wr_step + 1'b1;  // Wraps back to idle after the last word
			end
			if (start) begin
				frame_cnt <= CNT_W'(`MSG_INTERVAL - 1);
			end else if (frame_done && frame_cnt != '0) begin
				frame_cnt <= frame_cnt - 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// FIFO

	assign wr_en = (wr_step != 2'd0) & ~flush;
	assign rd_en = pop & (fill != '0) & ~flush;  // Pop on empty does nothing
	assign head  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				fill <= fill + 1'b1;
			end else if (rd_en && !wr_en) begin
				fill <= fill - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_word;
		end
	end

endmodule

//--- src/pixel_overlay.sv
`timescale 1ns/10ps

module pixel_overlay (
	input  video_pkg::video_beat_t beat,
	input  logic                   mode,
	input  logic                   video,
	input  video_pkg::coord_t      x,
	input  video_pkg::coord_t      y,
	input  video_pkg::box_t        box,
	input  video_pkg::pixel_t      bb_col,
	output video_pkg::video_beat_t out_beat
);

	logic       bright;
	logic       on_edge;
	logic [7:0] grey;

	assign bright = beat.pixel.red[7] & beat.pixel.green[7] & beat.pixel.blue[7];

	// Grey = green/2 + red/4 + blue/4, never above 253
	assign grey = beat.pixel.green[7:1] + beat.pixel.red[7:2] + beat.pixel.blue[7:2];

	assign on_edge = box.found & ((x == box.left) | (x == box.right) |
		(y == box.top) | (y == box.bottom));

	always_comb begin
		out_beat = beat;  // Marks always pass through
		if (mode && video && !beat.sop) begin
			if (on_edge) begin
				out_beat.pixel = bb_col;
			end else if (bright) begin
				out_beat.pixel = '{red: 8'hff, green: 8'hff, blue: 8'hff};
			end else begin
				out_beat.pixel = '{red: grey, green: grey, blue: grey};
			end
		end
	end

endmodule

//--- src/stream_stage.sv
`timescale 1ns/10ps

module stream_stage #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     reset_n,

	// Upstream side
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,

	// Downstream side
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// Accept when empty or when the held beat leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid & in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

//--- src/video_pkg.sv
package video_pkg;

	// One RGB pixel, red in the top byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	// Stream beat with packet marks
	typedef struct packed {
		pixel_t pixel;
		logic   sop;
		logic   eop;
	} video_beat_t;

	typedef logic [10:0] coord_t;

	// Bounding box of the bright pixels in one frame
	typedef struct packed {
		logic   found;
		coord_t left;
		coord_t right;
		coord_t top;
		coord_t bottom;
	} box_t;

endpackage
